// ==== nocPkg.sv ====
package nocPkg;

  // Mesh directions, one input port each.
  localparam int numPorts = 5;

  localparam int portLocal = 0;
  localparam int portNorth = 1;
  localparam int portEast = 2;
  localparam int portWest = 3;
  localparam int portSouth = 4;

  localparam int flitWidth = 32;
  localparam int destWidth = 8;
  localparam int lengthWidth = 12;
  localparam int flitIdWidth = 3;

  localparam logic [flitIdWidth-1:0] idHeader = 3'b001; // Body and tail codes carry no length.

  typedef logic [numPorts-1:0] grantVec;

  typedef struct packed
  {
    logic [destWidth-1:0] dest;
    logic [flitWidth-destWidth-lengthWidth-1:0] reserved;
    logic [lengthWidth-1:0] length; // Packet length in clock periods.
  } headerFields;

  typedef struct packed
  {
    logic [flitWidth-1:0] data;
  } payloadFields;

  // The same word is read as a header or as plain payload.
  typedef union packed
  {
    headerFields headerView;
    payloadFields payloadView;
  } flitWord;

endpackage

// ==== inPortIf.sv ====
interface inPortIf;

  logic req; // Level, held while a packet is pending.
  logic flitValid; // One-cycle strobe per flit.
  logic [nocPkg::flitIdWidth-1:0] flitId;
  nocPkg::flitWord flit;

  modport src
  (
    output req,
    output flitValid,
    output flitId,
    output flit
  );

  modport dst
  (
    input req,
    input flitValid,
    input flitId,
    input flit
  );

endinterface

// ==== grantTimer.sv ====
module grantTimer #(
  parameter int countWidth = nocPkg::lengthWidth
) (
  input logic clk,
  input logic rst,
  inPortIf.dst port,
  input logic runTimer,
  output logic timesUp
);

  logic [countWidth-1:0] count;
  logic [countWidth-1:0] holdLength;
  logic headerSeen;

  assign headerSeen = port.flitValid && (port.flitId == nocPkg::idHeader);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
      holdLength <= '0;
    end
    else
    begin
      if (headerSeen)
      begin
        holdLength <= countWidth'(port.flit.headerView.length);
      end
      if (runTimer)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0; // Count restarts for every new grant.
      end
    end
  end

  // Count starts at zero on the first granted cycle, so the grant lasts length+1 cycles.
  assign timesUp = (count == holdLength);

endmodule

// ==== portArbiter.sv ====
module portArbiter (
  input logic clk,
  input logic rst,
  inPortIf.dst ports [nocPkg::numPorts],
  input logic [nocPkg::numPorts-1:0] timesUp,
  output logic [nocPkg::numPorts-1:0] runTimer,
  output nocPkg::grantVec grant
);

  localparam int stateWidth = nocPkg::numPorts + 1;
  localparam logic [stateWidth-1:0] idleState = stateWidth'(1);

  // Bit 0 is idle, bit p+1 means port p owns the link.
  logic [stateWidth-1:0] state;
  logic [stateWidth-1:0] nextState;
  logic [nocPkg::numPorts-1:0] reqVec;

  for (genvar i = 0; i < nocPkg::numPorts; i++)
  begin : gReq
    assign reqVec[i] = ports[i].req;
  end

  // First requesting port among span ports, searching upward from start with wrap.
  function automatic logic [stateWidth-1:0] pickNext(
    input logic [nocPkg::numPorts-1:0] reqs,
    input int start,
    input int span
  );
    logic [stateWidth-1:0] pick;
    int idx;
    pick = idleState;
    for (int k = nocPkg::numPorts - 1; k >= 0; k--)
    begin
      idx = (start + k) % nocPkg::numPorts;
      if ((k < span) && reqs[idx])
      begin
        pick = stateWidth'(1) << (idx + 1); // Lowest offset is written last and wins.
      end
    end
    return pick;
  endfunction

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= idleState;
    end
    else
    begin
      state <= nextState;
    end
  end

  always_comb
  begin
    // Idle and any illegal state use the fixed order from Local to South.
    nextState = pickNext(reqVec, nocPkg::portLocal, nocPkg::numPorts);
    runTimer = '0;
    for (int p = 0; p < nocPkg::numPorts; p++)
    begin
      if (state[p+1])
      begin
        if (reqVec[p] && !timesUp[p])
        begin
          runTimer[p] = 1'b1;
          nextState = stateWidth'(1) << (p + 1);
        end
        else
        begin
          // Hand over to the other four ports, starting after p.
          nextState = pickNext(reqVec, (p + 1) % nocPkg::numPorts, nocPkg::numPorts - 1);
        end
      end
    end
  end

  assign grant = state[stateWidth-1:1]; // Registered, so it lags the request by one cycle.

endmodule

// ==== outputMux.sv ====
module outputMux (
  input logic clk,
  input logic rst,
  inPortIf.dst ports [nocPkg::numPorts],
  input nocPkg::grantVec grant,
  output logic outValid,
  output logic [nocPkg::flitIdWidth-1:0] outId,
  output nocPkg::flitWord outFlit
);

  logic [nocPkg::numPorts-1:0] validVec;
  logic [nocPkg::flitIdWidth-1:0] idArr [nocPkg::numPorts];
  logic [nocPkg::flitWidth-1:0] dataArr [nocPkg::numPorts];
  logic selValid;
  logic [nocPkg::flitIdWidth-1:0] selId;
  logic [nocPkg::flitWidth-1:0] selData;

  for (genvar i = 0; i < nocPkg::numPorts; i++)
  begin : gTap
    assign validVec[i] = ports[i].flitValid;
    assign idArr[i] = ports[i].flitId;
    assign dataArr[i] = ports[i].flit.payloadView.data;
  end

  // AND-OR select; grant is one-hot or zero.
  always_comb
  begin
    selValid = 1'b0;
    selId = '0;
    selData = '0;
    for (int p = 0; p < nocPkg::numPorts; p++)
    begin
      selValid |= grant[p] & validVec[p]; // Strobes of ungranted ports are dropped.
      selId |= {nocPkg::flitIdWidth{grant[p]}} & idArr[p];
      selData |= {nocPkg::flitWidth{grant[p]}} & dataArr[p];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= selValid;
    end
    if (selValid)
    begin
      outId <= selId;
      outFlit.payloadView.data <= selData;
    end
  end

endmodule

// ==== routerOutPort.sv ====
module routerOutPort #(
  parameter int countWidth = nocPkg::lengthWidth
) (
  input logic clk,
  input logic rst,
  input logic [nocPkg::numPorts-1:0] req,
  input logic [nocPkg::numPorts-1:0] flitValid,
  input logic [nocPkg::flitIdWidth-1:0] flitId [nocPkg::numPorts],
  input nocPkg::flitWord flit [nocPkg::numPorts],
  output nocPkg::grantVec grant,
  output logic outValid,
  output logic [nocPkg::flitIdWidth-1:0] outId,
  output nocPkg::flitWord outFlit
);

  logic [nocPkg::numPorts-1:0] runTimer;
  logic [nocPkg::numPorts-1:0] timesUp;

  inPortIf portIf [nocPkg::numPorts] ();

  for (genvar i = 0; i < nocPkg::numPorts; i++)
  begin : gPortMap
    assign portIf[i].req = req[i];
    assign portIf[i].flitValid = flitValid[i];
    assign portIf[i].flitId = flitId[i];
    assign portIf[i].flit = flit[i];
  end

  grantTimer #(.countWidth(countWidth)) timerLocal (
    .clk(clk),
    .rst(rst),
    .port(portIf[nocPkg::portLocal]),
    .runTimer(runTimer[nocPkg::portLocal]),
    .timesUp(timesUp[nocPkg::portLocal])
  );

  grantTimer #(.countWidth(countWidth)) timerNorth (
    .clk(clk),
    .rst(rst),
    .port(portIf[nocPkg::portNorth]),
    .runTimer(runTimer[nocPkg::portNorth]),
    .timesUp(timesUp[nocPkg::portNorth])
  );

  grantTimer #(.countWidth(countWidth)) timerEast (
    .clk(clk),
    .rst(rst),
    .port(portIf[nocPkg::portEast]),
    .runTimer(runTimer[nocPkg::portEast]),
    .timesUp(timesUp[nocPkg::portEast])
  );

  grantTimer #(.countWidth(countWidth)) timerWest (
    .clk(clk),
    .rst(rst),
    .port(portIf[nocPkg::portWest]),
    .runTimer(runTimer[nocPkg::portWest]),
    .timesUp(timesUp[nocPkg::portWest])
  );

  grantTimer #(.countWidth(countWidth)) timerSouth (
    .clk(clk),
    .rst(rst),
    .port(portIf[nocPkg::portSouth]),
    .runTimer(runTimer[nocPkg::portSouth]),
    .timesUp(timesUp[nocPkg::portSouth])
  );

  portArbiter arbiter (
    .clk(clk),
    .rst(rst),
    .ports(portIf),
    .timesUp(timesUp),
    .runTimer(runTimer),
    .grant(grant)
  );

  outputMux mux (
    .clk(clk),
    .rst(rst),
    .ports(portIf),
    .grant(grant),
    .outValid(outValid),
    .outId(outId),
    .outFlit(outFlit)
  );

endmodule

// ==== tbRouterOutPort.sv ====
module tbRouterOutPort;

  typedef struct packed
  {
    logic [nocPkg::numPorts-1:0] req;
    logic [nocPkg::numPorts-1:0] hdr; // Ports that send a header flit.
    logic [nocPkg::numPorts-1:0] pay; // Ports that send a body flit.
    logic [nocPkg::lengthWidth-1:0] len;
    int reps;
  } stimRow;

  logic clk = 1'b0;
  logic rst;
  logic [nocPkg::numPorts-1:0] req;
  logic [nocPkg::numPorts-1:0] flitValid;
  logic [nocPkg::flitIdWidth-1:0] flitId [nocPkg::numPorts];
  nocPkg::flitWord flit [nocPkg::numPorts];
  nocPkg::grantVec grant;
  logic outValid;
  logic [nocPkg::flitIdWidth-1:0] outId;
  nocPkg::flitWord outFlit;

  stimRow stimTable [$];
  logic [31:0] lfsrState = 32'h23330faf;
  int errors = 0;
  int checks = 0;

  // Reference state; owner -1 means the link is idle.
  int mOwner;
  logic [nocPkg::lengthWidth-1:0] mCount [nocPkg::numPorts];
  logic [nocPkg::lengthWidth-1:0] mLen [nocPkg::numPorts];
  logic expValid;
  logic [nocPkg::flitIdWidth-1:0] expId;
  logic [nocPkg::flitWidth-1:0] expData;

  routerOutPort #(.countWidth(nocPkg::lengthWidth)) DUT (
    .clk(clk),
    .rst(rst),
    .req(req),
    .flitValid(flitValid),
    .flitId(flitId),
    .flit(flit),
    .grant(grant),
    .outValid(outValid),
    .outId(outId),
    .outFlit(outFlit)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] drawBits(input int n);
    logic [31:0] value;
    logic fb;
    value = '0;
    for (int i = 0; i < n; i++)
    begin
      fb = lfsrState[0];
      lfsrState = lfsrState >> 1;
      if (fb)
      begin
        lfsrState ^= 32'hA3000000; // Galois taps applied on a one shifted out.
      end
      value = {value[30:0], fb};
    end
    return value;
  endfunction

  task automatic addRow(input logic [4:0] r, input logic [4:0] h, input logic [4:0] p,
                        input int len, input int reps);
    stimRow row;
    row.req = r;
    row.hdr = h;
    row.pay = p;
    row.len = nocPkg::lengthWidth'(len);
    row.reps = reps;
    stimTable.push_back(row);
  endtask

  task automatic applyRow(input stimRow row);
    logic [31:0] data;
    req = row.req;
    for (int p = 0; p < nocPkg::numPorts; p++)
    begin
      flitValid[p] = row.hdr[p] | row.pay[p];
      flitId[p] = '0;
      flit[p] = '0;
      if (row.hdr[p])
      begin
        flitId[p] = nocPkg::idHeader;
        flit[p].headerView.dest = 8'(p);
        flit[p].headerView.length = row.len;
      end
      else if (row.pay[p])
      begin
        data = drawBits(32);
        flitId[p] = 3'b010; // Body flit.
        flit[p].payloadView.data = data;
      end
    end
  endtask

  // Predicts the state after the coming rising edge from the current inputs.
  task automatic modelStep();
    logic [nocPkg::numPorts-1:0] run;
    int nextOwner;
    int idx;
    run = '0;
    nextOwner = -1;
    if (mOwner < 0)
    begin
      for (int k = 0; k < nocPkg::numPorts; k++)
      begin
        if (nextOwner < 0 && req[k])
        begin
          nextOwner = k;
        end
      end
    end
    else if (req[mOwner] && mCount[mOwner] != mLen[mOwner])
    begin
      run[mOwner] = 1'b1;
      nextOwner = mOwner;
    end
    else
    begin
      for (int k = 1; k < nocPkg::numPorts; k++)
      begin
        idx = (mOwner + k) % nocPkg::numPorts;
        if (nextOwner < 0 && req[idx])
        begin
          nextOwner = idx;
        end
      end
    end
    expValid = (mOwner >= 0) && flitValid[mOwner];
    if (expValid)
    begin
      expId = flitId[mOwner];
      expData = flit[mOwner].payloadView.data;
    end
    for (int p = 0; p < nocPkg::numPorts; p++)
    begin
      mCount[p] = run[p] ? mCount[p] + 1'b1 : '0;
      if (flitValid[p] && flitId[p] == nocPkg::idHeader)
      begin
        mLen[p] = flit[p].headerView.length;
      end
    end
    mOwner = nextOwner;
  endtask

  task automatic checkOutputs();
    nocPkg::grantVec expGrant;
    expGrant = (mOwner < 0) ? '0 : nocPkg::grantVec'(1) << mOwner;
    checks++;
    assert (grant === expGrant)
    else
    begin
      errors++;
      $display("Error at time %0t: grant is %b, expected %b", $time, grant, expGrant);
    end
    assert (outValid === expValid)
    else
    begin
      errors++;
      $display("Error at time %0t: outValid is %b, expected %b", $time, outValid, expValid);
    end
    if (expValid)
    begin
      assert (outId === expId && outFlit.payloadView.data === expData)
      else
      begin
        errors++;
        $display("Error at time %0t: output flit %0d/%h, expected %0d/%h", $time,
                 outId, outFlit.payloadView.data, expId, expData);
      end
    end
  endtask

  task automatic waitForIdle(input int limit);
    int cycles;
    cycles = 0;
    while (grant !== '0 && cycles < limit)
    begin
      @(negedge clk);
      cycles++;
    end
    if (grant !== '0)
    begin
      errors++;
      $display("Timeout: the grant did not return to zero within %0d cycles", limit);
    end
  endtask

  initial
  begin
    rst = 1'b1;
    req = '0;
    flitValid = '0;
    mOwner = -1;
    expValid = 1'b0;
    expId = '0;
    expData = '0;
    for (int p = 0; p < nocPkg::numPorts; p++)
    begin
      flitId[p] = '0;
      flit[p] = '0;
      mCount[p] = '0;
      mLen[p] = '0;
    end
    addRow(5'b00000, 5'b00000, 5'b00000, 0, 4); // Quiet link after reset.
    addRow(5'b00000, 5'b00001, 5'b00000, 1, 1); // Headers to idle ports are dropped.
    addRow(5'b00000, 5'b00010, 5'b00000, 2, 1);
    addRow(5'b00000, 5'b00100, 5'b00000, 3, 1);
    addRow(5'b00000, 5'b01000, 5'b00000, 0, 1);
    addRow(5'b00000, 5'b10000, 5'b00000, 2, 1);
    addRow(5'b11111, 5'b00000, 5'b11111, 0, 20); // Fixed order, then rotation.
    addRow(5'b00000, 5'b00000, 5'b00000, 0, 3);
    addRow(5'b00000, 5'b00001, 5'b00000, 20, 1);
    addRow(5'b00101, 5'b00000, 5'b00101, 0, 4);
    addRow(5'b00100, 5'b00000, 5'b00101, 0, 6); // Local releases early.
    addRow(5'b00000, 5'b00100, 5'b00000, 5, 1); // New hold time for East.
    addRow(5'b00100, 5'b00000, 5'b00100, 0, 10);
    addRow(5'b01010, 5'b00010, 5'b00000, 4, 1);
    addRow(5'b01010, 5'b00000, 5'b11111, 0, 14);
    addRow(5'b00000, 5'b00000, 5'b00000, 0, 3);
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    foreach (stimTable[i])
    begin
      for (int r = 0; r < stimTable[i].reps; r++)
      begin
        applyRow(stimTable[i]);
        modelStep();
        @(negedge clk);
        checkOutputs();
      end
    end
    req = '0;
    flitValid = '0;
    waitForIdle(16);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("Finished with no errors");
    end
    else
    begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== list.f ====
nocPkg.sv
inPortIf.sv
grantTimer.sv
portArbiter.sv
outputMux.sv
routerOutPort.sv
tbRouterOutPort.sv

// ==== runSim.sh ====
#!/bin/bash
# Builds the router output port testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module tbRouterOutPort -o simRouter \
  > build.log 2>&1 \
  && ./obj_dir/simRouter > sim.log 2>&1 \
  || { echo "Build or simulation failed"; exit 1; }
! grep -q "Finished with errors" sim.log && grep -q "Finished with no errors" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
